// ==== hdl/div_pkg.sv ====
// Shared widths and op encodings for the divide execution unit.
// Modules import this package inside their body and use scoped names
// in their port lists.

package div_pkg;

    // data path width, fixed by RV32
    localparam int XLEN = 32;

    // register file address and commit id widths
    localparam int REG_ADDR_W  = 5;
    localparam int COMMIT_ID_W = 3;

    // one-hot op vector and its bit positions
    localparam int OP_W    = 4;
    localparam int OP_DIV  = 0;
    localparam int OP_DIVU = 1;
    localparam int OP_REM  = 2;
    localparam int OP_REMU = 3;

    // number of iterative dividers behind the issue stage
    localparam int N_DIV = 2;

endpackage

// ==== hdl/div_issue.sv ====
`timescale 1ns/1ps
// Issue stage of the divide unit.
// Steers a request to the lowest idle divider, stalls the front end when
// every divider is busy, and keeps the write-back tags of each slot.

module div_issue (
    input  logic                                             clk,
    input  logic                                             rst_n_i,
    input  logic                                             req_div_i,
    input  logic                                             int_assert_i,
    input  logic [div_pkg::REG_ADDR_W-1:0]                   reg_waddr_i,
    input  logic [div_pkg::COMMIT_ID_W-1:0]                  commit_id_i,
    input  logic [div_pkg::N_DIV-1:0]                        core_busy_i,
    output logic [div_pkg::N_DIV-1:0]                        start_o,
    output logic                                             div_stall_o,
    output logic [div_pkg::N_DIV-1:0][div_pkg::REG_ADDR_W-1:0]  slot_waddr_o,
    output logic [div_pkg::N_DIV-1:0][div_pkg::COMMIT_ID_W-1:0] slot_commit_id_o
);
    import div_pkg::*;

    // request qualified by the interrupt
    logic req_ok;
    // set once some idle slot has been given the request
    logic placed;

    logic [N_DIV-1:0][REG_ADDR_W-1:0]  waddr_q;
    logic [N_DIV-1:0][COMMIT_ID_W-1:0] commit_id_q;

    // an interrupt in this cycle blocks the issue
    assign req_ok = req_div_i && !int_assert_i;

    // lowest numbered idle core wins
    always_comb begin
        start_o = '0;
        placed  = 1'b0;
        for (int s = 0; s < N_DIV; s++) begin
            if (req_ok && !core_busy_i[s] && !placed) begin
                start_o[s] = 1'b1;
                placed     = 1'b1;
            end
        end
    end

    // no core free, front end holds the request
    assign div_stall_o = req_ok && !placed;

    // tags follow the slot until write-back has taken the result
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            waddr_q     <= '0;
            commit_id_q <= '0;
        end else begin
            for (int s = 0; s < N_DIV; s++) begin
                if (start_o[s]) begin
                    waddr_q[s]     <= reg_waddr_i;
                    commit_id_q[s] <= commit_id_i;
                end
            end
        end
    end

    assign slot_waddr_o     = waddr_q;
    assign slot_commit_id_o = commit_id_q;

endmodule

// ==== hdl/div_core.sv ====
`timescale 1ns/1ps
// Radix-2 restoring divider for DIV, DIVU, REM and REMU.
// Takes a start pulse with operands, runs one quotient bit per cycle and
// holds its result until the write-back slot is ready for it.
// Latency from start to valid is XLEN+2 cycles without back-pressure.

module div_core (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     start_i,
    input  logic [div_pkg::OP_W-1:0] op_i,
    input  logic [div_pkg::XLEN-1:0] dividend_i,
    input  logic [div_pkg::XLEN-1:0] divisor_i,
    input  logic                     wb_ready_i,
    output logic [div_pkg::XLEN-1:0] result_o,
    output logic                     valid_o,
    output logic                     busy_o
);
    import div_pkg::*;

    // decode of the incoming request
    logic            op_signed;
    logic            op_rem;
    logic            dvd_neg;
    logic            dvs_neg;
    logic [XLEN-1:0] dvd_abs;
    logic [XLEN-1:0] dvs_abs;
    logic            div_zero;
    logic            div_ovf;
    logic            accept;

    // control state
    logic                    run_q;
    logic                    fix_q;
    logic                    done_q;
    logic [$clog2(XLEN)-1:0] iter_cnt;

    // operands and flags latched at start
    logic [XLEN-1:0] quo_q;
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] dvs_q;
    logic [XLEN-1:0] dvd_q;
    logic            q_neg_q;
    logic            r_neg_q;
    logic            want_rem_q;
    logic            zero_q;
    logic            ovf_q;

    // one step of the shift-subtract loop
    logic [XLEN:0]   shifted;
    logic [XLEN:0]   trial;

    // sign fix and corner substitution
    logic [XLEN-1:0] quo_fix;
    logic [XLEN-1:0] rem_fix;
    logic [XLEN-1:0] quo_final;
    logic [XLEN-1:0] rem_final;
    logic [XLEN-1:0] result_q;

    assign op_signed = op_i[OP_DIV] | op_i[OP_REM];
    assign op_rem    = op_i[OP_REM] | op_i[OP_REMU];

    assign dvd_neg = op_signed & dividend_i[XLEN-1];
    assign dvs_neg = op_signed & divisor_i[XLEN-1];
    assign dvd_abs = dvd_neg ? -dividend_i : dividend_i;
    assign dvs_abs = dvs_neg ? -divisor_i : divisor_i;

    assign div_zero = (divisor_i == '0);
    // most negative value over minus one
    assign div_ovf  = op_signed && (dividend_i == {1'b1, {(XLEN-1){1'b0}}}) && (&divisor_i);

    assign busy_o = run_q | fix_q | done_q;
    assign accept = start_i && !busy_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            run_q    <= 1'b0;
            fix_q    <= 1'b0;
            done_q   <= 1'b0;
            iter_cnt <= '0;
        end else if (accept) begin
            run_q    <= 1'b1;
            iter_cnt <= '0;
        end else if (run_q) begin
            iter_cnt <= iter_cnt + 1'b1;
            // last of the XLEN iterations
            if (&iter_cnt) begin
                run_q <= 1'b0;
                fix_q <= 1'b1;
            end
        end else if (fix_q) begin
            fix_q  <= 1'b0;
            done_q <= 1'b1;
        end else if (done_q && wb_ready_i) begin
            done_q <= 1'b0;
        end
    end

    // partial remainder takes the next dividend bit from the quotient reg
    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign trial   = shifted - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (accept) begin
            quo_q      <= dvd_abs;
            rem_q      <= '0;
            dvs_q      <= dvs_abs;
            dvd_q      <= dividend_i;
            q_neg_q    <= dvd_neg ^ dvs_neg;
            r_neg_q    <= dvd_neg;
            want_rem_q <= op_rem;
            zero_q     <= div_zero;
            ovf_q      <= div_ovf;
        end else if (run_q) begin
            // trial borrow means the divisor did not fit, restore
            quo_q <= {quo_q[XLEN-2:0], ~trial[XLEN]};
            rem_q <= trial[XLEN] ? shifted[XLEN-1:0] : trial[XLEN-1:0];
        end
    end

    // remainder takes the sign of the dividend
    assign quo_fix = q_neg_q ? -quo_q : quo_q;
    assign rem_fix = r_neg_q ? -rem_q : rem_q;

    always_comb begin
        if (zero_q) begin
            quo_final = '1;
            rem_final = dvd_q;
        end else if (ovf_q) begin
            quo_final = dvd_q;
            rem_final = '0;
        end else begin
            quo_final = quo_fix;
            rem_final = rem_fix;
        end
    end

    always_ff @(posedge clk) begin
        if (fix_q) begin
            result_q <= want_rem_q ? rem_final : quo_final;
        end
    end

    assign result_o = result_q;
    // result only leaves when write-back has room
    assign valid_o  = done_q & wb_ready_i;

endmodule

// ==== hdl/div_wb_arbiter.sv ====
`timescale 1ns/1ps
// Write-back stage of the divide unit.
// Buffers one finished result per divider with its tags and drives the
// single register write port, slot 0 first.

module div_wb_arbiter (
    input  logic                                                clk,
    input  logic                                                rst_n_i,
    input  logic [div_pkg::N_DIV-1:0]                           core_valid_i,
    input  logic [div_pkg::N_DIV-1:0][div_pkg::XLEN-1:0]        core_result_i,
    input  logic [div_pkg::N_DIV-1:0][div_pkg::REG_ADDR_W-1:0]  slot_waddr_i,
    input  logic [div_pkg::N_DIV-1:0][div_pkg::COMMIT_ID_W-1:0] slot_commit_id_i,
    input  logic                                                wb_ready_i,
    output logic [div_pkg::N_DIV-1:0]                           slot_ready_o,
    output logic                                                reg_we_o,
    output logic [div_pkg::XLEN-1:0]                            reg_wdata_o,
    output logic [div_pkg::REG_ADDR_W-1:0]                      reg_waddr_o,
    output logic [div_pkg::COMMIT_ID_W-1:0]                     commit_id_o
);
    import div_pkg::*;

    logic [N_DIV-1:0]                  buf_full;
    logic [N_DIV-1:0][XLEN-1:0]        buf_data;
    logic [N_DIV-1:0][REG_ADDR_W-1:0]  buf_waddr;
    logic [N_DIV-1:0][COMMIT_ID_W-1:0] buf_cid;

    // one-hot pick of the buffer on the write port
    logic [N_DIV-1:0] sel;
    logic [N_DIV-1:0] drain;

    // grant of the last cycle and whether the port refused it
    logic [N_DIV-1:0] sel_q;
    logic             hold_q;

    // a refused write keeps its slot, otherwise the lowest full slot wins
    always_comb begin
        sel = '0;
        if (hold_q) begin
            sel = sel_q;
        end else begin
            for (int s = 0; s < N_DIV; s++) begin
                if (buf_full[s] && (sel == '0)) begin
                    sel[s] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sel_q  <= '0;
            hold_q <= 1'b0;
        end else begin
            sel_q  <= sel;
            hold_q <= reg_we_o && !wb_ready_i;
        end
    end

    assign drain        = sel & {N_DIV{wb_ready_i}};
    // room now or room after this cycle's write
    assign slot_ready_o = ~buf_full | drain;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            buf_full <= '0;
        end else begin
            for (int s = 0; s < N_DIV; s++) begin
                if (core_valid_i[s]) begin
                    buf_full[s] <= 1'b1;
                end else if (drain[s]) begin
                    buf_full[s] <= 1'b0;
                end
            end
        end
    end

    // tags are still held by the issue stage when the result arrives
    always_ff @(posedge clk) begin
        for (int s = 0; s < N_DIV; s++) begin
            if (core_valid_i[s]) begin
                buf_data[s]  <= core_result_i[s];
                buf_waddr[s] <= slot_waddr_i[s];
                buf_cid[s]   <= slot_commit_id_i[s];
            end
        end
    end

    assign reg_we_o = |buf_full;

    // and-or mux that gives zero when nothing is pending
    always_comb begin
        reg_wdata_o = '0;
        reg_waddr_o = '0;
        commit_id_o = '0;
        for (int s = 0; s < N_DIV; s++) begin
            reg_wdata_o = reg_wdata_o | ({XLEN{sel[s]}} & buf_data[s]);
            reg_waddr_o = reg_waddr_o | ({REG_ADDR_W{sel[s]}} & buf_waddr[s]);
            commit_id_o = commit_id_o | ({COMMIT_ID_W{sel[s]}} & buf_cid[s]);
        end
    end

endmodule

// ==== hdl/div_unit.sv ====
`timescale 1ns/1ps
// Divide execution unit of the RV32 core.
// Accepts decoded DIV/DIVU/REM/REMU requests, runs them on two iterative
// dividers and returns results through one register write-back port.

module div_unit (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            wb_ready_i,
    input  logic                            req_div_i,
    input  logic                            div_op_div_i,
    input  logic                            div_op_divu_i,
    input  logic                            div_op_rem_i,
    input  logic                            div_op_remu_i,
    input  logic [div_pkg::XLEN-1:0]        reg1_rdata_i,
    input  logic [div_pkg::XLEN-1:0]        reg2_rdata_i,
    input  logic [div_pkg::REG_ADDR_W-1:0]  reg_waddr_i,
    input  logic [div_pkg::COMMIT_ID_W-1:0] commit_id_i,
    input  logic                            int_assert_i,
    output logic                            div_stall_o,
    output logic                            reg_we_o,
    output logic [div_pkg::XLEN-1:0]        reg_wdata_o,
    output logic [div_pkg::REG_ADDR_W-1:0]  reg_waddr_o,
    output logic [div_pkg::COMMIT_ID_W-1:0] commit_id_o
);
    import div_pkg::*;

    logic [OP_W-1:0]                   div_op;
    logic [N_DIV-1:0]                  core_start;
    logic [N_DIV-1:0]                  core_busy;
    logic [N_DIV-1:0]                  core_valid;
    logic [N_DIV-1:0]                  slot_ready;
    logic [N_DIV-1:0][XLEN-1:0]        core_result;
    logic [N_DIV-1:0][REG_ADDR_W-1:0]  slot_waddr;
    logic [N_DIV-1:0][COMMIT_ID_W-1:0] slot_commit_id;

    // decoder strobes into the one-hot op vector
    assign div_op[OP_DIV]  = div_op_div_i;
    assign div_op[OP_DIVU] = div_op_divu_i;
    assign div_op[OP_REM]  = div_op_rem_i;
    assign div_op[OP_REMU] = div_op_remu_i;

    div_issue u_issue (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .req_div_i        (req_div_i),
        .int_assert_i     (int_assert_i),
        .reg_waddr_i      (reg_waddr_i),
        .commit_id_i      (commit_id_i),
        .core_busy_i      (core_busy),
        .start_o          (core_start),
        .div_stall_o      (div_stall_o),
        .slot_waddr_o     (slot_waddr),
        .slot_commit_id_o (slot_commit_id)
    );

    // both cores see the same operands, only the start picks one
    div_core u_div0 (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .start_i    (core_start[0]),
        .op_i       (div_op),
        .dividend_i (reg1_rdata_i),
        .divisor_i  (reg2_rdata_i),
        .wb_ready_i (slot_ready[0]),
        .result_o   (core_result[0]),
        .valid_o    (core_valid[0]),
        .busy_o     (core_busy[0])
    );

    div_core u_div1 (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .start_i    (core_start[1]),
        .op_i       (div_op),
        .dividend_i (reg1_rdata_i),
        .divisor_i  (reg2_rdata_i),
        .wb_ready_i (slot_ready[1]),
        .result_o   (core_result[1]),
        .valid_o    (core_valid[1]),
        .busy_o     (core_busy[1])
    );

    div_wb_arbiter u_wb (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .core_valid_i     (core_valid),
        .core_result_i    (core_result),
        .slot_waddr_i     (slot_waddr),
        .slot_commit_id_i (slot_commit_id),
        .wb_ready_i       (wb_ready_i),
        .slot_ready_o     (slot_ready),
        .reg_we_o         (reg_we_o),
        .reg_wdata_o      (reg_wdata_o),
        .reg_waddr_o      (reg_waddr_o),
        .commit_id_o      (commit_id_o)
    );

endmodule

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ps
// Clock and reset source for the divide unit testbench.
// 4 ns clock period, reset held low for the first 10 cycles.

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== bench/div_unit_tb.sv ====
`timescale 1ns/1ps
// Table-driven testbench for the divide unit.
// Issues corner-case and random requests, checks every register write
// against a scoreboard keyed by commit id, and throttles wb_ready_i.

module div_unit_tb;
    import div_pkg::*;

    localparam int N_ENT   = 32;
    localparam int TIMEOUT = 2000;
    // commit id reserved for requests blocked by the interrupt
    localparam int INT_CID = 7;

    logic clk;
    logic rst_n;
    logic wb_ready_i;
    logic req_div_i;
    logic div_op_div_i;
    logic div_op_divu_i;
    logic div_op_rem_i;
    logic div_op_remu_i;
    logic [XLEN-1:0] reg1_rdata_i;
    logic [XLEN-1:0] reg2_rdata_i;
    logic [REG_ADDR_W-1:0] reg_waddr_i;
    logic [COMMIT_ID_W-1:0] commit_id_i;
    logic int_assert_i;
    logic div_stall_o;
    logic reg_we_o;
    logic [XLEN-1:0] reg_wdata_o;
    logic [REG_ADDR_W-1:0] reg_waddr_o;
    logic [COMMIT_ID_W-1:0] commit_id_o;

    // stimulus table
    int                     t_op    [N_ENT];
    logic [XLEN-1:0]        t_a     [N_ENT];
    logic [XLEN-1:0]        t_b     [N_ENT];
    logic [REG_ADDR_W-1:0]  t_waddr [N_ENT];
    logic [COMMIT_ID_W-1:0] t_cid   [N_ENT];
    logic                   t_int   [N_ENT];
    logic [XLEN-1:0]        t_exp   [N_ENT];
    int                     n_ent;

    // scoreboard indexed by commit id
    logic                  pending   [8];
    logic [XLEN-1:0]       exp_data  [8];
    logic [REG_ADDR_W-1:0] exp_waddr [8];

    bit   stall_seen;
    bit   run_done;
    logic prev_we;
    logic prev_ready;
    logic [XLEN-1:0]        prev_wdata;
    logic [REG_ADDR_W-1:0]  prev_waddr;
    logic [COMMIT_ID_W-1:0] prev_cid;

    tb_clk_gen u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    div_unit uut (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .wb_ready_i    (wb_ready_i),
        .req_div_i     (req_div_i),
        .div_op_div_i  (div_op_div_i),
        .div_op_divu_i (div_op_divu_i),
        .div_op_rem_i  (div_op_rem_i),
        .div_op_remu_i (div_op_remu_i),
        .reg1_rdata_i  (reg1_rdata_i),
        .reg2_rdata_i  (reg2_rdata_i),
        .reg_waddr_i   (reg_waddr_i),
        .commit_id_i   (commit_id_i),
        .int_assert_i  (int_assert_i),
        .div_stall_o   (div_stall_o),
        .reg_we_o      (reg_we_o),
        .reg_wdata_o   (reg_wdata_o),
        .reg_waddr_o   (reg_waddr_o),
        .commit_id_o   (commit_id_o)
    );

    // RV32M reference model with the corner cases checked first
    function automatic logic [XLEN-1:0] ref_result(int op, logic [XLEN-1:0] a,
                                                   logic [XLEN-1:0] b);
        logic [XLEN-1:0] q;
        logic [XLEN-1:0] r;
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (op == OP_DIVU || op == OP_REMU) begin
            q = a / b;
            r = a % b;
        end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            q = a;
            r = '0;
        end else begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end
        return (op == OP_REM || op == OP_REMU) ? r : q;
    endfunction

    function automatic bit any_pending();
        bit p;
        p = 1'b0;
        for (int c = 0; c < 8; c++) begin
            p = p | pending[c];
        end
        return p;
    endfunction

    task automatic add_entry(int op, logic [XLEN-1:0] a, logic [XLEN-1:0] b,
                             logic intr, logic [XLEN-1:0] exp, bit use_ref);
        t_op[n_ent]    = op;
        t_a[n_ent]     = a;
        t_b[n_ent]     = b;
        t_waddr[n_ent] = REG_ADDR_W'(n_ent + 1);
        t_cid[n_ent]   = intr ? COMMIT_ID_W'(INT_CID) : COMMIT_ID_W'(n_ent % 7);
        t_int[n_ent]   = intr;
        t_exp[n_ent]   = use_ref ? ref_result(op, a, b) : exp;
        n_ent++;
    endtask

    task automatic fail_timeout(string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // write port back-pressure in random stretches
    task automatic throttle_ready();
        while (!run_done) begin
            repeat (20 + $urandom_range(40)) @(negedge clk);
            wb_ready_i = 1'b0;
            repeat (4 + $urandom_range(36)) @(negedge clk);
            wb_ready_i = 1'b1;
        end
    endtask

    // called and returning on a falling edge
    task automatic issue_entry(int i);
        int   cnt;
        logic [COMMIT_ID_W-1:0] cid;
        cid = t_cid[i];
        cnt = 0;
        while (!t_int[i] && pending[cid]) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) fail_timeout("a free commit id");
        end
        req_div_i     = 1'b1;
        div_op_div_i  = (t_op[i] == OP_DIV);
        div_op_divu_i = (t_op[i] == OP_DIVU);
        div_op_rem_i  = (t_op[i] == OP_REM);
        div_op_remu_i = (t_op[i] == OP_REMU);
        reg1_rdata_i  = t_a[i];
        reg2_rdata_i  = t_b[i];
        reg_waddr_i   = t_waddr[i];
        commit_id_i   = cid;
        int_assert_i  = t_int[i];
        cnt = 0;
        while (!t_int[i]) begin
            #1;
            if (!div_stall_o) break;
            stall_seen = 1'b1;
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) fail_timeout("the stall to clear");
        end
        if (t_int[i]) begin
            #1;
            assert (!div_stall_o) else begin
                $display("ERR %0t stall raised for an interrupted request", $time);
                $display("Test FAILED");
                $fatal(1);
            end
        end else begin
            pending[cid]   = 1'b1;
            exp_data[cid]  = t_exp[i];
            exp_waddr[cid] = t_waddr[i];
        end
        @(negedge clk);
        req_div_i    = 1'b0;
        int_assert_i = 1'b0;
    endtask

    // write-back monitor
    always @(posedge clk) begin
        if (rst_n) begin
            if (prev_we && !prev_ready) begin
                assert (reg_we_o && reg_wdata_o == prev_wdata &&
                        reg_waddr_o == prev_waddr && commit_id_o == prev_cid) else begin
                    $display("ERR %0t write port changed while wb_ready_i was low", $time);
                    $display("Test FAILED");
                    $fatal(1);
                end
            end
            if (reg_we_o && wb_ready_i) begin
                assert (commit_id_o != INT_CID && pending[commit_id_o]) else begin
                    $display("ERR %0t unexpected write, commit id %0d", $time, commit_id_o);
                    $display("Test FAILED");
                    $fatal(1);
                end
                assert (reg_wdata_o == exp_data[commit_id_o] &&
                        reg_waddr_o == exp_waddr[commit_id_o]) else begin
                    $display("ERR %0t cid %0d got data %h reg %0d, expected %h reg %0d",
                             $time, commit_id_o, reg_wdata_o, reg_waddr_o,
                             exp_data[commit_id_o], exp_waddr[commit_id_o]);
                    $display("Test FAILED");
                    $fatal(1);
                end
                pending[commit_id_o] = 1'b0;
            end
        end
        prev_we    <= reg_we_o;
        prev_ready <= wb_ready_i;
        prev_wdata <= reg_wdata_o;
        prev_waddr <= reg_waddr_o;
        prev_cid   <= commit_id_o;
    end

    initial begin
        int cnt;
        void'($urandom(32'hd6c3a460));
        wb_ready_i    = 1'b1;
        req_div_i     = 1'b0;
        div_op_div_i  = 1'b0;
        div_op_divu_i = 1'b0;
        div_op_rem_i  = 1'b0;
        div_op_remu_i = 1'b0;
        reg1_rdata_i  = '0;
        reg2_rdata_i  = '0;
        reg_waddr_i   = '0;
        commit_id_i   = '0;
        int_assert_i  = 1'b0;
        prev_we       = 1'b0;
        prev_ready    = 1'b1;
        for (int c = 0; c < 8; c++) begin
            pending[c] = 1'b0;
        end
        n_ent = 0;
        // ordinary signs
        add_entry(OP_DIV,  32'd100,        32'd7,          0, 32'd14,         0);
        add_entry(OP_REM,  32'd100,        32'd7,          0, 32'd2,          0);
        add_entry(OP_DIV,  -32'sd100,      32'd7,          0, 32'hffff_fff2,  0);
        add_entry(OP_REM,  -32'sd100,      32'd7,          0, 32'hffff_fffe,  0);
        add_entry(OP_DIV,  -32'sd100,      -32'sd7,        0, 32'd14,         0);
        add_entry(OP_DIVU, 32'hffff_ffff,  32'd2,          0, 32'h7fff_ffff,  0);
        add_entry(OP_REMU, 32'hffff_ffff,  32'd2,          0, 32'd1,          0);
        // interrupted request that must never be written
        add_entry(OP_DIV,  32'd55,         32'd5,          1, 32'd11,         0);
        // divide by zero
        add_entry(OP_DIV,  32'h0000_1234,  32'd0,          0, 32'hffff_ffff,  0);
        add_entry(OP_REM,  32'h0000_1234,  32'd0,          0, 32'h0000_1234,  0);
        add_entry(OP_DIVU, 32'd5,          32'd0,          0, 32'hffff_ffff,  0);
        add_entry(OP_REMU, 32'd5,          32'd0,          0, 32'd5,          0);
        // signed overflow and its unsigned twin
        add_entry(OP_DIV,  32'h8000_0000,  32'hffff_ffff,  0, 32'h8000_0000,  0);
        add_entry(OP_REM,  32'h8000_0000,  32'hffff_ffff,  0, 32'd0,          0);
        add_entry(OP_DIVU, 32'h8000_0000,  32'hffff_ffff,  0, 32'd0,          0);
        add_entry(OP_REMU, 32'h8000_0000,  32'hffff_ffff,  0, 32'h8000_0000,  0);
        while (n_ent < N_ENT) begin
            add_entry($urandom_range(3), $urandom,
                      (n_ent % 2) ? $urandom : 32'($urandom_range(1000)) - 32'd500,
                      0, '0, 1);
        end
        cnt = 0;
        while (!rst_n) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) fail_timeout("reset release");
        end
        assert (!reg_we_o && !div_stall_o) else begin
            $display("ERR %0t outputs not idle after reset", $time);
            $display("Test FAILED");
            $fatal(1);
        end
        fork
            throttle_ready();
        join_none
        for (int i = 0; i < n_ent; i++) begin
            issue_entry(i);
        end
        cnt = 0;
        while (any_pending()) begin
            @(negedge clk);
            cnt++;
            if (cnt > 4 * TIMEOUT) fail_timeout("the final drain");
        end
        run_done = 1'b1;
        if (stall_seen) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("no stall was seen with both dividers busy");
            $display("Test FAILED");
            $fatal(1);
        end
    end

endmodule

// ==== verilog.f ====
hdl/div_pkg.sv
hdl/div_issue.sv
hdl/div_core.sv
hdl/div_wb_arbiter.sv
hdl/div_unit.sv
bench/tb_clk_gen.sv
bench/div_unit_tb.sv

// ==== Bender.yml ====
package:
  name: div_unit

sources:
  - hdl/div_pkg.sv
  - hdl/div_issue.sv
  - hdl/div_core.sv
  - hdl/div_wb_arbiter.sv
  - hdl/div_unit.sv
  - target: simulation
    files:
      - bench/tb_clk_gen.sv
      - bench/div_unit_tb.sv
